// ==== design/ldu_cq_cfg_pkg.sv ====
/*
    load unit central queue configuration
    widths of the core fields the queue tracks, plus derived constants
*/

package ldu_cq_cfg_pkg;

    // ----------------------------------------
    // core widths

    localparam int LOG_ROB_ENTRIES = 7;
    localparam int LOG_PR_COUNT = 7;

    // ----------------------------------------
    // memory side widths

    // physical address with byte offset bits dropped
    localparam int PA_WORD_WIDTH = 30;
    localparam int PPN_WIDTH = 20;

    // page offset in words, what is left of the PA word under the PPN
    localparam int PO_WORD_WIDTH = PA_WORD_WIDTH - PPN_WIDTH;

    localparam int LOAD_OP_WIDTH = 4;
    localparam int BYTE_MASK_WIDTH = 4;
    localparam int DATA_WIDTH = 32;

endpackage

// ==== design/ldu_cq_msg_pkg.sv ====
/*
    load unit central queue messages
    packed structs for each message entering or leaving the queue
*/

package ldu_cq_msg_pkg;

    import ldu_cq_cfg_pkg::*;

    // ----------------------------------------
    // inbound

    // issued load from dispatch
    typedef struct packed {
        logic [LOAD_OP_WIDTH-1:0]   op;
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } ldu_enq_t;

    // pipeline result for one entry
    // both hit bits high is a clean hit
    typedef struct packed {
        logic                       dtlb_hit;
        logic                       dcache_hit;
        logic [PA_WORD_WIDTH-1:0]   PA_word;
        logic [BYTE_MASK_WIDTH-1:0] byte_mask;
        logic [DATA_WIDTH-1:0]      data;
    } ldu_info_ret_t;

    // translation filled after a dtlb miss
    typedef struct packed {
        logic [PA_WORD_WIDTH-1:0] PA_word;
    } dtlb_resp_t;

    // load data after a dcache miss
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
    } dcache_resp_t;

    // ----------------------------------------
    // outbound

    // re-access once the translation is known
    typedef struct packed {
        logic [PPN_WIDTH-1:0]       PPN;
        logic [PO_WORD_WIDTH-1:0]   PO_word;
        logic [BYTE_MASK_WIDTH-1:0] byte_mask;
    } second_try_t;

    // writeback of load data
    typedef struct packed {
        logic [DATA_WIDTH-1:0]      data;
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
    } data_try_t;

endpackage

// ==== design/ldu_cq_entry_array.sv ====
/*
    load unit central queue entry array
    circular entry storage, per-entry event handling, commit marking,
    head dequeue with credit return, and payload read-out for launches
*/

module ldu_cq_entry_array import ldu_cq_cfg_pkg::*, ldu_cq_msg_pkg::*; #(
    parameter int LDU_CQ_ENTRIES = 8,
    localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES)
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // enqueue
    input  logic                            enq_valid,
    input  ldu_enq_t                        enq,
    output logic                            credit_ret,

    // pipeline info return
    input  logic                            info_ret_valid,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   info_ret_cq_index,
    input  ldu_info_ret_t                   info_ret,

    // miss responses
    input  logic                            dtlb_resp_valid,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   dtlb_resp_cq_index,
    input  dtlb_resp_t                      dtlb_resp,
    input  logic                            dcache_resp_valid,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   dcache_resp_cq_index,
    input  dcache_resp_t                    dcache_resp,

    // commit
    input  logic                            commit_valid,
    input  logic [LOG_ROB_ENTRIES-1:0]      commit_ROB_index,

    // requests to arbiters
    output logic [LDU_CQ_ENTRIES-1:0]       second_try_req_vec,
    output logic [LDU_CQ_ENTRIES-1:0]       data_try_req_vec,
    output logic [LDU_CQ_ENTRIES-1:0]       complete_req_vec,
    output logic [LOG_LDU_CQ_ENTRIES-1:0]   head_index,

    // accepted picks
    input  logic [LDU_CQ_ENTRIES-1:0]       second_try_grant,
    input  logic [LDU_CQ_ENTRIES-1:0]       data_try_grant,
    input  logic [LDU_CQ_ENTRIES-1:0]       complete_grant,

    // launch read ports
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   second_try_cq_index,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   data_try_cq_index,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   complete_cq_index,
    output second_try_t                     second_try,
    output data_try_t                       data_try,
    output logic [LOG_ROB_ENTRIES-1:0]      ldu_complete_ROB_index
);

    // ----------------------------------------
    // entry record

    typedef struct packed {
        logic valid;
        logic committed;
        logic complete;
        logic second_try_req;
        logic data_try_req;
        logic complete_req;
    } entry_ctrl_t;

    typedef struct packed {
        logic [LOG_PR_COUNT-1:0]    dest_PR;
        logic [LOG_ROB_ENTRIES-1:0] ROB_index;
        logic [PA_WORD_WIDTH-1:0]   PA_word;
        logic [BYTE_MASK_WIDTH-1:0] byte_mask;
        logic [DATA_WIDTH-1:0]      data;
    } entry_data_t;

    entry_ctrl_t [LDU_CQ_ENTRIES-1:0] ctrl_q, ctrl_d;
    entry_data_t [LDU_CQ_ENTRIES-1:0] data_q;

    logic [LOG_LDU_CQ_ENTRIES-1:0] enq_ptr, deq_ptr;
    logic deq_perform;

    logic [LDU_CQ_ENTRIES-1:0] info_ret_by_entry;
    logic [LDU_CQ_ENTRIES-1:0] dtlb_resp_by_entry;
    logic [LDU_CQ_ENTRIES-1:0] dcache_resp_by_entry;
    logic [LDU_CQ_ENTRIES-1:0] valid_vec;

    // ----------------------------------------
    // event decode

    always_comb begin
        info_ret_by_entry = '0;
        dtlb_resp_by_entry = '0;
        dcache_resp_by_entry = '0;
        info_ret_by_entry[info_ret_cq_index] = info_ret_valid;
        dtlb_resp_by_entry[dtlb_resp_cq_index] = dtlb_resp_valid;
        dcache_resp_by_entry[dcache_resp_cq_index] = dcache_resp_valid;
    end

    // head leaves once complete and committed
    assign deq_perform = ctrl_q[deq_ptr].valid & ctrl_q[deq_ptr].complete
        & ctrl_q[deq_ptr].committed;

    // ----------------------------------------
    // per-entry state

    always_comb begin
        ctrl_d = ctrl_q;
        for (int i = 0; i < LDU_CQ_ENTRIES; i++) begin
            valid_vec[i] = ctrl_q[i].valid;

            // picks taken by the launch stages
            if (second_try_grant[i]) ctrl_d[i].second_try_req = 1'b0;
            if (data_try_grant[i]) ctrl_d[i].data_try_req = 1'b0;
            if (complete_grant[i]) begin
                ctrl_d[i].complete_req = 1'b0;
                ctrl_d[i].complete = 1'b1;
            end

            // clean hit goes straight to writeback
            // a miss of either kind waits for its response
            if (info_ret_by_entry[i] & info_ret.dtlb_hit & info_ret.dcache_hit) begin
                ctrl_d[i].data_try_req = 1'b1;
                ctrl_d[i].complete_req = 1'b1;
            end
            if (dtlb_resp_by_entry[i]) ctrl_d[i].second_try_req = 1'b1;
            if (dcache_resp_by_entry[i]) begin
                ctrl_d[i].data_try_req = 1'b1;
                ctrl_d[i].complete_req = 1'b1;
            end

            if (commit_valid & ctrl_q[i].valid & (data_q[i].ROB_index == commit_ROB_index)) begin
                ctrl_d[i].committed = 1'b1;
            end
        end

        if (deq_perform) ctrl_d[deq_ptr] = '0;
        if (enq_valid) begin
            ctrl_d[enq_ptr] = '0;
            ctrl_d[enq_ptr].valid = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            ctrl_q <= '0;
            enq_ptr <= '0;
            deq_ptr <= '0;
            credit_ret <= 1'b0;
        end else begin
            ctrl_q <= ctrl_d;
            credit_ret <= deq_perform;
            if (enq_valid) begin
                enq_ptr <= (enq_ptr == LOG_LDU_CQ_ENTRIES'(LDU_CQ_ENTRIES - 1)) ? '0
                    : enq_ptr + 1'b1;
            end
            if (deq_perform) begin
                deq_ptr <= (deq_ptr == LOG_LDU_CQ_ENTRIES'(LDU_CQ_ENTRIES - 1)) ? '0
                    : deq_ptr + 1'b1;
            end
        end
    end

    // payload fields
    always_ff @(posedge CLK) begin
        if (enq_valid) begin
            data_q[enq_ptr].dest_PR <= enq.dest_PR;
            data_q[enq_ptr].ROB_index <= enq.ROB_index;
        end
        if (info_ret_valid) begin
            data_q[info_ret_cq_index].PA_word <= info_ret.PA_word;
            data_q[info_ret_cq_index].byte_mask <= info_ret.byte_mask;
            data_q[info_ret_cq_index].data <= info_ret.data;
        end
        if (dtlb_resp_valid) data_q[dtlb_resp_cq_index].PA_word <= dtlb_resp.PA_word;
        if (dcache_resp_valid) data_q[dcache_resp_cq_index].data <= dcache_resp.data;
    end

    // ----------------------------------------
    // requests and read-out

    always_comb begin
        for (int i = 0; i < LDU_CQ_ENTRIES; i++) begin
            second_try_req_vec[i] = ctrl_q[i].second_try_req;
            data_try_req_vec[i] = ctrl_q[i].data_try_req;
            complete_req_vec[i] = ctrl_q[i].complete_req;
        end
    end

    assign head_index = deq_ptr;

    always_comb begin
        second_try.PPN = data_q[second_try_cq_index].PA_word[PA_WORD_WIDTH-1 -: PPN_WIDTH];
        second_try.PO_word = data_q[second_try_cq_index].PA_word[PO_WORD_WIDTH-1:0];
        second_try.byte_mask = data_q[second_try_cq_index].byte_mask;
        data_try.data = data_q[data_try_cq_index].data;
        data_try.dest_PR = data_q[data_try_cq_index].dest_PR;
        data_try.ROB_index = data_q[data_try_cq_index].ROB_index;
        ldu_complete_ROB_index = data_q[complete_cq_index].ROB_index;
    end

    // dispatcher credits must keep enqueue off live entries
    a_enq_free: assert property (@(posedge CLK) disable iff (~nRST)
        enq_valid |-> ~ctrl_q[enq_ptr].valid);

    // pipeline and miss handlers only answer for loads still queued
    a_event_live: assert property (@(posedge CLK) disable iff (~nRST)
        ~|((info_ret_by_entry | dtlb_resp_by_entry | dcache_resp_by_entry) & ~valid_vec));

endmodule

// ==== design/ldu_cq_oldest_arbiter.sv ====
/*
    oldest-first arbiter with launch register
    picks the requesting entry nearest the head, wrapping past the end,
    and holds the pick in a valid/ack launch stage
*/

module ldu_cq_oldest_arbiter #(
    parameter int LDU_CQ_ENTRIES = 8,
    localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES)
) (
    input  logic                            CLK,
    input  logic                            nRST,

    input  logic [LDU_CQ_ENTRIES-1:0]       req_vec,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   head_index,

    input  logic                            ack,
    output logic                            launch_valid,
    output logic [LOG_LDU_CQ_ENTRIES-1:0]   launch_index,

    output logic [LDU_CQ_ENTRIES-1:0]       grant
);

    logic [LDU_CQ_ENTRIES-1:0] masked_req;
    logic [LDU_CQ_ENTRIES-1:0] pick_one_hot;
    logic [LOG_LDU_CQ_ENTRIES-1:0] pick_index;
    logic load_en;

    // ----------------------------------------
    // pick

    always_comb begin
        for (int i = 0; i < LDU_CQ_ENTRIES; i++) begin
            masked_req[i] = req_vec[i] & (i >= int'(head_index));
        end

        // lowest overall, overridden by lowest at or above head
        pick_index = '0;
        for (int i = LDU_CQ_ENTRIES - 1; i >= 0; i--) begin
            if (req_vec[i]) pick_index = LOG_LDU_CQ_ENTRIES'(i);
        end
        for (int i = LDU_CQ_ENTRIES - 1; i >= 0; i--) begin
            if (masked_req[i]) pick_index = LOG_LDU_CQ_ENTRIES'(i);
        end

        pick_one_hot = '0;
        pick_one_hot[pick_index] = |req_vec;
    end

    // ----------------------------------------
    // launch stage

    // stalled only by a valid launch still waiting on ack
    assign load_en = ~(launch_valid & ~ack);

    always_ff @(posedge CLK, negedge nRST) begin
        if (~nRST) begin
            launch_valid <= 1'b0;
            launch_index <= '0;
        end else if (load_en) begin
            launch_valid <= |req_vec;
            launch_index <= pick_index;
        end
    end

    assign grant = pick_one_hot & {LDU_CQ_ENTRIES{load_en}};

    a_grant_onehot: assert property (@(posedge CLK) disable iff (~nRST)
        $onehot0(grant));

    a_hold: assert property (@(posedge CLK) disable iff (~nRST)
        launch_valid & ~ack |=> launch_valid & $stable(launch_index));

endmodule

// ==== design/ldu_cq.sv ====
/*
    load unit central queue
    tracks issued loads in order and launches second tries, data tries
    and completion notices for them
*/

module ldu_cq import ldu_cq_cfg_pkg::*, ldu_cq_msg_pkg::*; #(
    parameter int LDU_CQ_ENTRIES = 8,
    localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES)
) (
    input  logic                            CLK,
    input  logic                            nRST,

    // enqueue from dispatch, credit based
    input  logic                            enq_valid,
    input  ldu_enq_t                        enq,
    output logic                            credit_ret,

    // pipeline info return
    input  logic                            info_ret_valid,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   info_ret_cq_index,
    input  ldu_info_ret_t                   info_ret,

    // dtlb miss response
    input  logic                            dtlb_resp_valid,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   dtlb_resp_cq_index,
    input  dtlb_resp_t                      dtlb_resp,

    // dcache miss response
    input  logic                            dcache_resp_valid,
    input  logic [LOG_LDU_CQ_ENTRIES-1:0]   dcache_resp_cq_index,
    input  dcache_resp_t                    dcache_resp,

    // second try
    output logic                            second_try_valid,
    output logic [LOG_LDU_CQ_ENTRIES-1:0]   second_try_cq_index,
    output second_try_t                     second_try,
    input  logic                            second_try_ack,

    // data try
    output logic                            data_try_valid,
    output logic [LOG_LDU_CQ_ENTRIES-1:0]   data_try_cq_index,
    output data_try_t                       data_try,
    input  logic                            data_try_ack,

    // ROB completion, never back-pressured
    output logic                            ldu_complete_valid,
    output logic [LOG_ROB_ENTRIES-1:0]      ldu_complete_ROB_index,

    // ROB commit
    input  logic                            commit_valid,
    input  logic [LOG_ROB_ENTRIES-1:0]      commit_ROB_index
);

    logic [LDU_CQ_ENTRIES-1:0] second_try_req_vec, data_try_req_vec, complete_req_vec;
    logic [LDU_CQ_ENTRIES-1:0] second_try_grant, data_try_grant, complete_grant;
    logic [LOG_LDU_CQ_ENTRIES-1:0] head_index;
    logic [LOG_LDU_CQ_ENTRIES-1:0] complete_cq_index;

    // ----------------------------------------
    // entries

    ldu_cq_entry_array #(.LDU_CQ_ENTRIES(LDU_CQ_ENTRIES)) entry_array_i (
        .CLK, .nRST,
        .enq_valid, .enq, .credit_ret,
        .info_ret_valid, .info_ret_cq_index, .info_ret,
        .dtlb_resp_valid, .dtlb_resp_cq_index, .dtlb_resp,
        .dcache_resp_valid, .dcache_resp_cq_index, .dcache_resp,
        .commit_valid, .commit_ROB_index,
        .second_try_req_vec, .data_try_req_vec, .complete_req_vec,
        .head_index,
        .second_try_grant, .data_try_grant, .complete_grant,
        .second_try_cq_index, .data_try_cq_index, .complete_cq_index,
        .second_try, .data_try, .ldu_complete_ROB_index
    );

    // ----------------------------------------
    // launch arbiters

    ldu_cq_oldest_arbiter #(.LDU_CQ_ENTRIES(LDU_CQ_ENTRIES)) second_try_arb_i (
        .CLK, .nRST,
        .req_vec(second_try_req_vec), .head_index,
        .ack(second_try_ack),
        .launch_valid(second_try_valid), .launch_index(second_try_cq_index),
        .grant(second_try_grant)
    );

    ldu_cq_oldest_arbiter #(.LDU_CQ_ENTRIES(LDU_CQ_ENTRIES)) data_try_arb_i (
        .CLK, .nRST,
        .req_vec(data_try_req_vec), .head_index,
        .ack(data_try_ack),
        .launch_valid(data_try_valid), .launch_index(data_try_cq_index),
        .grant(data_try_grant)
    );

    // ROB always takes the notice
    ldu_cq_oldest_arbiter #(.LDU_CQ_ENTRIES(LDU_CQ_ENTRIES)) complete_arb_i (
        .CLK, .nRST,
        .req_vec(complete_req_vec), .head_index,
        .ack(1'b1),
        .launch_valid(ldu_complete_valid), .launch_index(complete_cq_index),
        .grant(complete_grant)
    );

endmodule

// ==== tb/ldu_cq_tb.sv ====
/*
    testbench for the load unit central queue
    runs a table of loads through hit, dcache miss and dtlb miss paths,
    then checks credits and oldest-first launch order under back-pressure
*/

module ldu_cq_tb import ldu_cq_cfg_pkg::*, ldu_cq_msg_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ENTRIES = 8;
    localparam int LOG_ENTRIES = $clog2(ENTRIES);
    localparam int ROWS = 8;
    localparam int LOG_DEPTH = 64;
    localparam int WAIT_LIMIT = 50;

    localparam logic [1:0] KIND_HIT = 2'd0;
    localparam logic [1:0] KIND_DCACHE = 2'd1;
    localparam logic [1:0] KIND_DTLB = 2'd2;

    localparam int SEL_CREDIT = 0;
    localparam int SEL_ST = 1;
    localparam int SEL_DT = 2;
    localparam int SEL_CMP = 3;

    typedef struct packed {
        logic [1:0]                 kind;
        logic [LOG_ROB_ENTRIES-1:0] rob;
        logic [LOG_PR_COUNT-1:0]    dest;
        logic [PA_WORD_WIDTH-1:0]   pa;
        logic [BYTE_MASK_WIDTH-1:0] mask;
        logic [DATA_WIDTH-1:0]      ret_data;
        logic [DATA_WIDTH-1:0]      miss_data;
    } row_t;

    logic CLK, nRST;
    logic enq_valid, credit_ret;
    ldu_enq_t enq;
    logic info_ret_valid, dtlb_resp_valid, dcache_resp_valid;
    logic [LOG_ENTRIES-1:0] info_ret_cq_index, dtlb_resp_cq_index, dcache_resp_cq_index;
    ldu_info_ret_t info_ret;
    dtlb_resp_t dtlb_resp;
    dcache_resp_t dcache_resp;
    logic second_try_valid, second_try_ack, data_try_valid, data_try_ack;
    logic [LOG_ENTRIES-1:0] second_try_cq_index, data_try_cq_index;
    second_try_t second_try;
    data_try_t data_try;
    logic ldu_complete_valid, commit_valid;
    logic [LOG_ROB_ENTRIES-1:0] ldu_complete_ROB_index, commit_ROB_index;

    row_t tbl [ROWS];
    int slot_of [ROWS];
    int enq_slot, credits;
    int errors, checks, tests, failed;

    // launches seen by the monitor
    int credit_count, st_count, dt_count, cmp_count;
    second_try_t st_log [LOG_DEPTH];
    logic [LOG_ENTRIES-1:0] st_idx_log [LOG_DEPTH];
    data_try_t dt_log [LOG_DEPTH];
    logic [LOG_ENTRIES-1:0] dt_idx_log [LOG_DEPTH];
    logic [LOG_ROB_ENTRIES-1:0] cmp_log [LOG_DEPTH];

    ldu_cq #(.LDU_CQ_ENTRIES(ENTRIES)) dut_i (
        .CLK, .nRST,
        .enq_valid, .enq, .credit_ret,
        .info_ret_valid, .info_ret_cq_index, .info_ret,
        .dtlb_resp_valid, .dtlb_resp_cq_index, .dtlb_resp,
        .dcache_resp_valid, .dcache_resp_cq_index, .dcache_resp,
        .second_try_valid, .second_try_cq_index, .second_try, .second_try_ack,
        .data_try_valid, .data_try_cq_index, .data_try, .data_try_ack,
        .ldu_complete_valid, .ldu_complete_ROB_index,
        .commit_valid, .commit_ROB_index
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // ----------------------------------------
    // monitor, samples mid-cycle

    always @(negedge CLK) begin
        if (nRST) begin
            if (credit_ret) begin
                credit_count++;
                credits++;
            end
            if (second_try_valid & second_try_ack & (st_count < LOG_DEPTH)) begin
                st_log[st_count] = second_try;
                st_idx_log[st_count] = second_try_cq_index;
                st_count++;
            end
            if (data_try_valid & data_try_ack & (dt_count < LOG_DEPTH)) begin
                dt_log[dt_count] = data_try;
                dt_idx_log[dt_count] = data_try_cq_index;
                dt_count++;
            end
            if (ldu_complete_valid & (cmp_count < LOG_DEPTH)) begin
                cmp_log[cmp_count] = ldu_complete_ROB_index;
                cmp_count++;
            end
        end
    end

    // ----------------------------------------
    // helpers

    task automatic next_cycle();
        @(posedge CLK);
        #1;
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: %0d error(s)", name, errors - err_before);
        end
    endtask

    function automatic int count_of(input int sel);
        case (sel)
            SEL_CREDIT: return credit_count;
            SEL_ST: return st_count;
            SEL_DT: return dt_count;
            default: return cmp_count;
        endcase
    endfunction

    task automatic wait_count(input int sel, input int target, input string what);
        int n;
        n = 0;
        while ((count_of(sel) < target) && (n < WAIT_LIMIT)) begin
            next_cycle();
            n++;
        end
        if (count_of(sel) < target) begin
            $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
            errors++;
        end
    endtask

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            KIND_HIT: return "hit";
            KIND_DCACHE: return "dcache miss";
            default: return "dtlb miss";
        endcase
    endfunction

    function automatic bit completed(input logic [LOG_ROB_ENTRIES-1:0] rob, input int from);
        for (int i = from; (i < cmp_count) && (i < LOG_DEPTH); i++) begin
            if (cmp_log[i] == rob) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic set_row(input int r, input logic [1:0] kind,
                           input logic [LOG_ROB_ENTRIES-1:0] rob,
                           input logic [LOG_PR_COUNT-1:0] dest,
                           input logic [BYTE_MASK_WIDTH-1:0] mask);
        tbl[r].kind = kind;
        tbl[r].rob = rob;
        tbl[r].dest = dest;
        tbl[r].mask = mask;
        tbl[r].pa = PA_WORD_WIDTH'($urandom);
        tbl[r].ret_data = $urandom;
        tbl[r].miss_data = $urandom;
    endtask

    // ----------------------------------------
    // drivers

    // dispatcher side, spends one credit per load
    task automatic enqueue(input int r, input int limit, output bit sent);
        int n;
        n = 0;
        while ((credits == 0) && (n < limit)) begin
            next_cycle();
            n++;
        end
        sent = (credits > 0);
        if (sent) begin
            enq_valid = 1'b1;
            enq.op = 4'h2;
            enq.dest_PR = tbl[r].dest;
            enq.ROB_index = tbl[r].rob;
            credits--;
            slot_of[r] = enq_slot;
            enq_slot = (enq_slot + 1) % ENTRIES;
            next_cycle();
            enq_valid = 1'b0;
        end
    endtask

    task automatic send_info(input int idx, input logic dtlb_hit, input logic dcache_hit,
                             input logic [PA_WORD_WIDTH-1:0] pa,
                             input logic [BYTE_MASK_WIDTH-1:0] mask,
                             input logic [DATA_WIDTH-1:0] data);
        info_ret_valid = 1'b1;
        info_ret_cq_index = LOG_ENTRIES'(idx);
        info_ret.dtlb_hit = dtlb_hit;
        info_ret.dcache_hit = dcache_hit;
        info_ret.PA_word = pa;
        info_ret.byte_mask = mask;
        info_ret.data = data;
        next_cycle();
        info_ret_valid = 1'b0;
    endtask

    task automatic send_dtlb(input int idx, input logic [PA_WORD_WIDTH-1:0] pa);
        dtlb_resp_valid = 1'b1;
        dtlb_resp_cq_index = LOG_ENTRIES'(idx);
        dtlb_resp.PA_word = pa;
        next_cycle();
        dtlb_resp_valid = 1'b0;
    endtask

    task automatic send_dcache(input int idx, input logic [DATA_WIDTH-1:0] data);
        dcache_resp_valid = 1'b1;
        dcache_resp_cq_index = LOG_ENTRIES'(idx);
        dcache_resp.data = data;
        next_cycle();
        dcache_resp_valid = 1'b0;
    endtask

    task automatic send_commit(input logic [LOG_ROB_ENTRIES-1:0] rob);
        commit_valid = 1'b1;
        commit_ROB_index = rob;
        next_cycle();
        commit_valid = 1'b0;
    endtask

    task automatic check_data_try(input int pos, input int r, input logic [DATA_WIDTH-1:0] exp);
        check("data_try.data", 64'(dt_log[pos].data), 64'(exp));
        check("data_try.dest_PR", 64'(dt_log[pos].dest_PR), 64'(tbl[r].dest));
        check("data_try.ROB_index", 64'(dt_log[pos].ROB_index), 64'(tbl[r].rob));
        check("data_try_cq_index", 64'(dt_idx_log[pos]), 64'(slot_of[r]));
    endtask

    // ----------------------------------------
    // tests

    task automatic run_row(input int r);
        int err0, dt0, cmp0, st0, idx;
        logic [DATA_WIDTH-1:0] exp_data;
        err0 = errors;
        dt0 = dt_count;
        cmp0 = cmp_count;
        st0 = st_count;
        idx = slot_of[r];
        exp_data = (tbl[r].kind == KIND_DCACHE) ? tbl[r].miss_data : tbl[r].ret_data;
        case (tbl[r].kind)
            KIND_HIT: send_info(idx, 1'b1, 1'b1, tbl[r].pa, tbl[r].mask, tbl[r].ret_data);
            KIND_DCACHE: begin
                send_info(idx, 1'b1, 1'b0, tbl[r].pa, tbl[r].mask, tbl[r].ret_data);
                idle(10);
                check("data tries before dcache response", 64'(dt_count), 64'(dt0));
                send_dcache(idx, tbl[r].miss_data);
            end
            default: begin
                // translation unknown yet, so the PA here is junk
                send_info(idx, 1'b0, 1'b0, ~tbl[r].pa, tbl[r].mask, tbl[r].ret_data);
                send_dtlb(idx, tbl[r].pa);
                wait_count(SEL_ST, st0 + 1, "second try");
                check("second_try.PPN", 64'(st_log[st0].PPN),
                    64'(tbl[r].pa >> PO_WORD_WIDTH));
                check("second_try.PO_word", 64'(st_log[st0].PO_word),
                    64'(tbl[r].pa) % (64'd1 << PO_WORD_WIDTH));
                check("second_try.byte_mask", 64'(st_log[st0].byte_mask), 64'(tbl[r].mask));
                check("second_try_cq_index", 64'(st_idx_log[st0]), 64'(idx));
                idle(3);
                check("data tries before second access", 64'(dt_count), 64'(dt0));
                send_info(idx, 1'b1, 1'b1, tbl[r].pa, tbl[r].mask, tbl[r].ret_data);
            end
        endcase
        wait_count(SEL_DT, dt0 + 1, "data try");
        wait_count(SEL_CMP, cmp0 + 1, "completion");
        idle(4);
        check("data try count", 64'(dt_count), 64'(dt0 + 1));
        check("completion count", 64'(cmp_count), 64'(cmp0 + 1));
        check_data_try(dt0, r, exp_data);
        check("ldu_complete_ROB_index", 64'(cmp_log[cmp0]), 64'(tbl[r].rob));
        end_test($sformatf("row %0d %s", r, kind_name(tbl[r].kind)), err0);
    endtask

    // hits come back youngest first while the data try port is stalled
    task automatic backpressure_test(input int n, input string name);
        int err0, dt0, cmp0, cr0, wait_n, r;
        bit sent;
        err0 = errors;
        dt0 = dt_count;
        cmp0 = cmp_count;
        cr0 = credit_count;
        data_try_ack = 1'b0;
        for (int k = 0; k < n; k++) begin
            enqueue(k, WAIT_LIMIT, sent);
            if (!sent) begin
                $display("dispatcher had no credit for load %0d", k);
                errors++;
            end
        end
        for (int k = n - 1; k >= 0; k--) begin
            send_info(slot_of[k], 1'b1, 1'b1, tbl[k].pa, tbl[k].mask, tbl[k].ret_data);
        end

        wait_n = 0;
        do begin
            @(negedge CLK);
            wait_n++;
        end while (!data_try_valid && (wait_n < WAIT_LIMIT));
        if (!data_try_valid) begin
            $display("data try valid never rose while ack was held low");
            errors++;
        end

        // first hit back is already in the launch register
        repeat (6) begin
            check("data_try_valid under back-pressure", 64'(data_try_valid), 64'(1));
            check("data_try.data under back-pressure", 64'(data_try.data),
                64'(tbl[n-1].ret_data));
            check("data_try.dest_PR under back-pressure", 64'(data_try.dest_PR),
                64'(tbl[n-1].dest));
            check("data_try.ROB_index under back-pressure", 64'(data_try.ROB_index),
                64'(tbl[n-1].rob));
            check("data_try_cq_index under back-pressure", 64'(data_try_cq_index),
                64'(slot_of[n-1]));
            @(negedge CLK);
        end

        next_cycle();
        data_try_ack = 1'b1;
        wait_count(SEL_DT, dt0 + n, "data try after ack");
        for (int k = 0; k < n; k++) begin
            r = (k == 0) ? n - 1 : k - 1;
            check_data_try(dt0 + k, r, tbl[r].ret_data);
        end

        wait_count(SEL_CMP, cmp0 + n, "completion");
        for (int k = 0; k < n; k++) begin
            check($sformatf("completion of ROB %0d", tbl[k].rob),
                64'(completed(tbl[k].rob, cmp0)), 64'(1));
        end
        for (int k = 0; k < n; k++) send_commit(tbl[k].rob);
        wait_count(SEL_CREDIT, cr0 + n, "credit return");
        idle(4);
        check("credit_ret pulses", 64'(credit_count), 64'(cr0 + n));
        end_test(name, err0);
    endtask

    // ----------------------------------------
    // main sequence

    initial begin
        int err0;
        bit sent;

        nRST = 1'b0;
        enq_valid = 1'b0;
        enq = '0;
        info_ret_valid = 1'b0;
        info_ret_cq_index = '0;
        info_ret = '0;
        dtlb_resp_valid = 1'b0;
        dtlb_resp_cq_index = '0;
        dtlb_resp = '0;
        dcache_resp_valid = 1'b0;
        dcache_resp_cq_index = '0;
        dcache_resp = '0;
        second_try_ack = 1'b1;
        data_try_ack = 1'b1;
        commit_valid = 1'b0;
        commit_ROB_index = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        failed = 0;
        credit_count = 0;
        st_count = 0;
        dt_count = 0;
        cmp_count = 0;
        enq_slot = 0;
        credits = ENTRIES;

        void'($urandom(46));
        set_row(0, KIND_HIT, 7'd12, 7'd33, 4'hf);
        set_row(1, KIND_DCACHE, 7'd13, 7'd34, 4'h3);
        set_row(2, KIND_DTLB, 7'd14, 7'd35, 4'hc);
        set_row(3, KIND_HIT, 7'd15, 7'd40, 4'h1);
        set_row(4, KIND_DTLB, 7'd16, 7'd41, 4'hf);
        set_row(5, KIND_DCACHE, 7'd17, 7'd42, 4'h6);
        set_row(6, KIND_HIT, 7'd18, 7'd50, 4'h8);
        set_row(7, KIND_HIT, 7'd19, 7'd51, 4'hf);

        repeat (5) @(posedge CLK);
        #1;
        nRST = 1'b1;
        next_cycle();

        // fill every entry, nothing commits yet
        err0 = errors;
        for (int r = 0; r < ROWS; r++) begin
            enqueue(r, WAIT_LIMIT, sent);
        end
        idle(10);
        check("credit_ret pulses while full", 64'(credit_count), 64'(0));
        check("credits left", 64'(credits), 64'(0));
        enqueue(0, 20, sent);
        check("ninth enqueue sent", 64'(sent), 64'(0));
        end_test("credits withheld when full", err0);

        for (int r = 0; r < ROWS; r++) run_row(r);

        err0 = errors;
        for (int r = 0; r < ROWS; r++) send_commit(tbl[r].rob);
        wait_count(SEL_CREDIT, ROWS, "credit return");
        idle(5);
        check("credit_ret pulses", 64'(credit_count), 64'(ROWS));
        check("credits held", 64'(credits), 64'(ENTRIES));
        end_test("credit return on dequeue", err0);

        backpressure_test(4, "oldest first under back-pressure");
        backpressure_test(6, "oldest first across the wrap");

        $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src.f ====
design/ldu_cq_cfg_pkg.sv
design/ldu_cq_msg_pkg.sv
design/ldu_cq_entry_array.sv
design/ldu_cq_oldest_arbiter.sv
design/ldu_cq.sv
tb/ldu_cq_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the load unit queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -f src.f --top-module ldu_cq_tb -o ldu_cq_sim
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

./obj_dir/ldu_cq_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi

exit 0
